/* flist.f */
+incdir+src
src/text_term_pkg.sv
src/ps2_rx.sv
src/key_decoder.sv
src/text_buffer.sv
src/vga_text_render.sv
src/text_term.sv
dv/text_term_asserts.sv
dv/tb_checker.sv
dv/tb_text_term.sv

/* dv/tb_text_term.sv */
`timescale 1ns/1ps
`include "text_term_macros.svh"

module tb_text_term;

	localparam int CLK_NS = 8;
	localparam int PS2_HALF = 20;
	localparam int RANDOM_KEYS = 48;
	localparam int WRAP_KEYS = 90;
	localparam int CHECKS = 2;
	// worst case frame count over both phases
	localparam int MAX_FRAMES = RANDOM_KEYS * 3 + (RANDOM_KEYS / 12) * 3 + 2 * `ROWS +
		WRAP_KEYS + 12;
	localparam int VIDEO_CLKS = (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK) *
		(`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
	localparam int WATCHDOG_NS = (MAX_FRAMES * 12 * 2 * PS2_HALF +
		(2 * CHECKS + 1) * VIDEO_CLKS + 100000) * CLK_NS;

	// set-2 make codes, A to Z, 0 to 9, space, Enter
	localparam logic [8*38-1:0] KEY_CODES = {
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
		8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
		8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h45, 8'h16, 8'h1E, 8'h26,
		8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h29, 8'h5A
	};
	localparam logic [8*38-1:0] KEY_CHARS = {"ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789 ", 8'h0A};
	// esc, F1, backspace, left shift
	localparam logic [8*4-1:0] UNMAPPED = {8'h76, 8'h05, 8'h66, 8'h12};

	logic clk;
	logic rst_n;
	logic ps2_clk;
	logic ps2_data;
	logic check_req;
	logic hsync;
	logic vsync;
	logic blank_n;
	logic frame_error;
	text_term_pkg::ascii_t char_code;
	text_term_pkg::glyph_row_t glyph_row;
	text_term_pkg::glyph_col_t glyph_col;

	text_term_pkg::ascii_t model_screen [0:`CELLS-1];
	bit model_written [0:`CELLS-1];
	int model_cursor;
	int bad_frames_sent;
	int frames_checked;
	int timing_errs;
	int pixel_errs;
	int fe_errs;
	int assert_errs;
	logic [31:0] lfsr_state;

	text_term text_term_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.char_code(char_code),
		.glyph_row(glyph_row),
		.glyph_col(glyph_col),
		.frame_error(frame_error)
	);

	tb_checker tb_checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.char_code(char_code),
		.glyph_row(glyph_row),
		.glyph_col(glyph_col),
		.frame_error(frame_error),
		.check_req(check_req),
		.frames_checked(frames_checked),
		.timing_errs(timing_errs),
		.pixel_errs(pixel_errs),
		.fe_errs(fe_errs)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int take_bits(int n);
		int r;
		r = 0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = (r << 1) | int'(lfsr_state[0]);
		end
		return r;
	endfunction

	// 0 when the code has no character
	function automatic text_term_pkg::ascii_t expected_char(text_term_pkg::scan_code_t code);
		for (int k = 0; k < 38; k++) begin
			if (KEY_CODES[8*k +: 8] == code) begin
				return KEY_CHARS[8*k +: 8];
			end
		end
		return 8'h00;
	endfunction

	task automatic model_apply(text_term_pkg::ascii_t c);
		if (c == `CHAR_NEWLINE) begin
			if (model_cursor / `COLS == `ROWS - 1) begin
				model_cursor = 0;
			end else begin
				model_cursor = (model_cursor / `COLS + 1) * `COLS;
			end
		end else if (c != 8'h00) begin
			model_screen[model_cursor] = c;
			model_written[model_cursor] = 1'b1;
			model_cursor = (model_cursor == `CELLS - 1) ? 0 : model_cursor + 1;
		end
	endtask

	// start, 8 data bits lsb first, odd parity, stop
	task automatic send_frame(text_term_pkg::scan_code_t code, logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~^code ^ bad_parity, code, 1'b0};
		for (int b = 0; b < 11; b++) begin
			@(negedge clk);
			ps2_data = bits[b];
			repeat (PS2_HALF - 1) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (PS2_HALF) @(negedge clk);
			ps2_clk = 1'b1;
		end
		repeat (2 * PS2_HALF) @(negedge clk);
	endtask

	task automatic press_key(text_term_pkg::scan_code_t code, logic with_break);
		send_frame(code, 1'b0);
		model_apply(expected_char(code));
		if (with_break) begin
			send_frame(`KEY_BREAK, 1'b0);
			send_frame(code, 1'b0);
		end
	endtask

	task automatic type_letters(int count);
		int k;
		for (int n = 0; n < count; n++) begin
			k = 1 + take_bits(6) % 37;
			press_key(KEY_CODES[8*k +: 8], 1'b0);
		end
	endtask

	task automatic check_one_frame();
		int target;
		target = frames_checked + 1;
		check_req = 1'b1;
		wait (frames_checked == target);
		check_req = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int k;
		rst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		check_req = 1'b0;
		model_cursor = 0;
		bad_frames_sent = 0;
		lfsr_state = 32'hd3c9_5003;
		for (int c = 0; c < `CELLS; c++) begin
			model_screen[c] = 8'h00;
			model_written[c] = 1'b0;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		repeat (20) @(negedge clk);

		// random keys, some released, with unmapped keys mixed in
		for (int n = 0; n < RANDOM_KEYS; n++) begin
			k = take_bits(6) % 38;
			press_key(KEY_CODES[8*k +: 8], logic'(take_bits(1)));
			if (n % 12 == 5) begin
				press_key(UNMAPPED[8*(n/12) +: 8], 1'b1);
			end
		end
		check_one_frame();

		// bad parity must not move the cursor
		send_frame(8'h15, 1'b1);
		bad_frames_sent++;
		type_letters(3);
		while (model_cursor / `COLS != `ROWS - 1) begin
			press_key(`KEY_ENTER, 1'b0);
		end
		type_letters(5);
		// newline on the last row goes back to cell 0
		press_key(`KEY_ENTER, 1'b0);
		type_letters(3);
		while (model_cursor / `COLS != `ROWS - 1) begin
			press_key(`KEY_ENTER, 1'b0);
		end
		type_letters(WRAP_KEYS);
		check_one_frame();

		assert_errs = text_term_inst.text_term_asserts_inst.assert_fails;
		$display("checked %0d frames, errors: timing %0d, pixel %0d, frame_error %0d, assertion %0d",
			frames_checked, timing_errs, pixel_errs, fe_errs, assert_errs);
		if (timing_errs + pixel_errs + fe_errs + assert_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* dv/tb_checker.sv */
`timescale 1ns/1ps
`include "text_term_macros.svh"

module tb_checker (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      hsync,
	input  logic                      vsync,
	input  logic                      blank_n,
	input  text_term_pkg::ascii_t     char_code,
	input  text_term_pkg::glyph_row_t glyph_row,
	input  text_term_pkg::glyph_col_t glyph_col,
	input  logic                      frame_error,
	input  logic                      check_req,
	output int                        frames_checked,
	output int                        timing_errs,
	output int                        pixel_errs,
	output int                        fe_errs
);

	localparam int LINE_CLKS = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int FRAME_CLKS = LINE_CLKS * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);

	int cyc;
	int hs_fall_at;
	int vs_fall_at;
	int bl_rise_at;
	int line_cnt;
	int fe_cnt;
	int x;
	int idx;
	logic hs_q;
	logic vs_q;
	logic bl_q;
	logic fe_q;
	logic after_reset;
	logic checking;

	task automatic timing_error(string msg);
		timing_errs++;
		$display("** Error @ %0t: %s", $time, msg);
	endtask

	// only the first few pixel mismatches are printed
	task automatic pixel_error(string msg);
		if (pixel_errs < 20) begin
			$display("** Error @ %0t: %s", $time, msg);
		end
		pixel_errs++;
	endtask

	initial begin
		frames_checked = 0;
		timing_errs = 0;
		pixel_errs = 0;
		fe_errs = 0;
	end

	always @(negedge clk) begin
		if (!rst_n) begin
			cyc = 0;
			hs_fall_at = -1;
			vs_fall_at = -1;
			bl_rise_at = 0;
			line_cnt = 0;
			fe_cnt = 0;
			hs_q = 1'b1;
			vs_q = 1'b1;
			bl_q = 1'b0;
			fe_q = 1'b0;
			after_reset = 1'b1;
			checking = 1'b0;
		end else begin
			if (after_reset && (blank_n !== 1'b0 || hsync !== 1'b1 || vsync !== 1'b1)) begin
				timing_error($sformatf("after reset blank_n %b hsync %b vsync %b, expected 0 1 1",
					blank_n, hsync, vsync));
			end
			after_reset = 1'b0;
			cyc++;
			if (hs_q && !hsync) begin
				if (hs_fall_at >= 0 && cyc - hs_fall_at != LINE_CLKS) begin
					timing_error($sformatf("line period %0d clocks, expected %0d",
						cyc - hs_fall_at, LINE_CLKS));
				end
				hs_fall_at = cyc;
			end
			if (!hs_q && hsync && cyc - hs_fall_at != `H_SYNC) begin
				timing_error($sformatf("hsync low for %0d clocks", cyc - hs_fall_at));
			end
			if (!vs_q && vsync && cyc - vs_fall_at != `V_SYNC * LINE_CLKS) begin
				timing_error($sformatf("vsync low for %0d clocks", cyc - vs_fall_at));
			end
			if (bl_q && !blank_n) begin
				if (cyc - bl_rise_at != `H_ACTIVE) begin
					timing_error($sformatf("blank_n high for %0d clocks", cyc - bl_rise_at));
				end
				line_cnt++;
			end
			if (!bl_q && blank_n) begin
				bl_rise_at = cyc;
			end
			if (vs_q && !vsync) begin
				if (vs_fall_at >= 0 && cyc - vs_fall_at != FRAME_CLKS) begin
					timing_error($sformatf("frame period %0d clocks", cyc - vs_fall_at));
				end
				if (line_cnt != `V_ACTIVE) begin
					timing_error($sformatf("%0d active lines in a frame", line_cnt));
				end
				vs_fall_at = cyc;
				line_cnt = 0;
				if (checking) begin
					checking = 1'b0;
					frames_checked++;
				end else if (check_req) begin
					checking = 1'b1;
					if (fe_cnt != tb_text_term.bad_frames_sent) begin
						fe_errs++;
						$display("** Error @ %0t: %0d frame_error pulses, expected %0d",
							$time, fe_cnt, tb_text_term.bad_frames_sent);
					end
				end
			end
			if (frame_error) begin
				if (fe_q) begin
					fe_errs++;
					$display("** Error @ %0t: frame_error longer than one cycle", $time);
				end else begin
					fe_cnt++;
				end
			end
			if (checking && blank_n) begin
				x = cyc - bl_rise_at;
				idx = (line_cnt / `CELL_H) * `COLS + x / `CELL_W;
				if (glyph_row !== 4'(line_cnt % `CELL_H) || glyph_col !== 3'(x % `CELL_W)) begin
					pixel_error($sformatf("pixel (%0d,%0d) glyph row/col %0d/%0d", x, line_cnt,
						glyph_row, glyph_col));
				end
				if (tb_text_term.model_written[idx] &&
					char_code !== tb_text_term.model_screen[idx]) begin
					pixel_error($sformatf("pixel (%0d,%0d) char_code %02h, expected %02h", x,
						line_cnt, char_code, tb_text_term.model_screen[idx]));
				end
			end else if (checking && char_code !== 8'h00) begin
				pixel_error($sformatf("char_code %02h outside the active area", char_code));
			end
			hs_q = hsync;
			vs_q = vsync;
			bl_q = blank_n;
			fe_q = frame_error;
		end
	end

endmodule

/* dv/text_term_asserts.sv */
`timescale 1ns/1ps

module text_term_asserts (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      code_valid,
	input logic                      frame_error,
	input logic                      ch_valid,
	input logic                      hsync,
	input logic                      vsync,
	input logic                      blank_n,
	input text_term_pkg::rx_state_t  rx_state,
	input logic                      rx_fall
);

	int assert_fails = 0;

	strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(code_valid && frame_error))
		else begin
			assert_fails++;
			$error("code_valid and frame_error high in the same cycle");
		end

	ch_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
		ch_valid |=> !ch_valid)
		else begin
			assert_fails++;
			$error("ch_valid high for more than one cycle");
		end

	// no visible pixels while a sync pulse is active
	blank_in_sync: assert property (@(posedge clk) disable iff (!rst_n)
		(!hsync || !vsync) |-> !blank_n)
		else begin
			assert_fails++;
			$error("blank_n high during hsync or vsync");
		end

	// the stop bit edge ends the frame
	stop_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(rx_state == text_term_pkg::STOP && rx_fall) |=>
		(rx_state == text_term_pkg::IDLE) && (code_valid || frame_error))
		else begin
			assert_fails++;
			$error("receiver did not return to IDLE with a strobe after STOP");
		end

endmodule

bind text_term text_term_asserts text_term_asserts_inst (
	.clk(clk),
	.rst_n(rst_n),
	.code_valid(code_valid),
	.frame_error(frame_error),
	.ch_valid(ch_valid),
	.hsync(hsync),
	.vsync(vsync),
	.blank_n(blank_n),
	.rx_state(ps2_rx_inst.state),
	.rx_fall(ps2_rx_inst.ps2_fall)
);

/* src/text_term.sv */
`timescale 1ns/1ps

module text_term (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ps2_clk,
	input  logic                      ps2_data,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      blank_n,
	output text_term_pkg::ascii_t     char_code,
	output text_term_pkg::glyph_row_t glyph_row,
	output text_term_pkg::glyph_col_t glyph_col,
	output logic                      frame_error
);

	text_term_pkg::scan_code_t code;
	logic code_valid;
	text_term_pkg::ascii_t ch;
	logic ch_valid;
	text_term_pkg::cell_addr_t rd_addr;
	text_term_pkg::ascii_t rd_data;

	// keyboard side
	ps2_rx ps2_rx_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.code(code),
		.code_valid(code_valid),
		.frame_error(frame_error)
	);

	key_decoder key_decoder_inst (
		.clk(clk),
		.rst_n(rst_n),
		.code(code),
		.code_valid(code_valid),
		.ch(ch),
		.ch_valid(ch_valid)
	);

	text_buffer text_buffer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ch(ch),
		.ch_valid(ch_valid),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	// display side
	vga_text_render vga_text_render_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.char_code(char_code),
		.glyph_row(glyph_row),
		.glyph_col(glyph_col)
	);

endmodule

/* src/vga_text_render.sv */
`timescale 1ns/1ps
`include "text_term_macros.svh"

module vga_text_render (
	input  logic                      clk,
	input  logic                      rst_n,
	output text_term_pkg::cell_addr_t rd_addr,
	input  text_term_pkg::ascii_t     rd_data,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      blank_n,
	output text_term_pkg::ascii_t     char_code,
	output text_term_pkg::glyph_row_t glyph_row,
	output text_term_pkg::glyph_col_t glyph_col
);

	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

	text_term_pkg::pix_x_t h_cnt;
	text_term_pkg::pix_y_t v_cnt;
	logic active_0;
	logic hsync_0;
	logic vsync_0;
	logic [6:0] cell_col;
	logic [4:0] cell_row;

	logic active_1;
	logic hsync_1;
	logic vsync_1;
	text_term_pkg::glyph_row_t grow_1;
	text_term_pkg::glyph_col_t gcol_1;

	// stage 0 raster counters
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == 10'(H_TOTAL - 1)) begin
			h_cnt <= '0;
			if (v_cnt == 10'(V_TOTAL - 1)) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	assign active_0 = (h_cnt < 10'(`H_ACTIVE)) && (v_cnt < 10'(`V_ACTIVE));
	assign hsync_0 = !((h_cnt >= 10'(`H_ACTIVE + `H_FRONT)) &&
		(h_cnt < 10'(`H_ACTIVE + `H_FRONT + `H_SYNC)));
	assign vsync_0 = !((v_cnt >= 10'(`V_ACTIVE + `V_FRONT)) &&
		(v_cnt < 10'(`V_ACTIVE + `V_FRONT + `V_SYNC)));

	assign cell_col = 7'(h_cnt / `CELL_W);
	assign cell_row = 5'(v_cnt / `CELL_H);

	// kept in range during blanking
	assign rd_addr = active_0 ?
		(12'(cell_row) * 12'(`COLS) + 12'(cell_col)) : '0;

	// stage 1 lines up with rd_data
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_1 <= 1'b0;
			hsync_1 <= 1'b1;
			vsync_1 <= 1'b1;
		end else begin
			active_1 <= active_0;
			hsync_1 <= hsync_0;
			vsync_1 <= vsync_0;
		end
	end

	always_ff @(posedge clk) begin
		grow_1 <= 4'(v_cnt % `CELL_H);
		gcol_1 <= 3'(h_cnt % `CELL_W);
	end

	// stage 2 outputs
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			hsync <= hsync_1;
			vsync <= vsync_1;
			blank_n <= active_1;
		end
	end

	always_ff @(posedge clk) begin
		char_code <= active_1 ? rd_data : 8'h00;
		glyph_row <= grow_1;
		glyph_col <= gcol_1;
	end

endmodule

/* src/text_buffer.sv */
`timescale 1ns/1ps
`include "text_term_macros.svh"

module text_buffer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  text_term_pkg::ascii_t     ch,
	input  logic                      ch_valid,
	input  text_term_pkg::cell_addr_t rd_addr,
	output text_term_pkg::ascii_t     rd_data
);

	text_term_pkg::ascii_t mem [0:`CELLS-1];
	logic [6:0] cur_col;
	logic [4:0] cur_row;
	text_term_pkg::cell_addr_t cur_idx;
	logic is_newline;

	assign is_newline = (ch == `CHAR_NEWLINE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cur_col <= 7'd0;
			cur_row <= 5'd0;
			cur_idx <= '0;
		end else if (ch_valid) begin
			if (is_newline) begin
				cur_col <= 7'd0;
				if (cur_row == 5'(`ROWS - 1)) begin
					cur_row <= 5'd0;
					cur_idx <= '0;
				end else begin
					cur_row <= cur_row + 5'd1;
					// jump to the start of the next row
					cur_idx <= cur_idx + (12'(`COLS) - {5'd0, cur_col});
				end
			end else if (cur_idx == 12'(`CELLS - 1)) begin
				cur_col <= 7'd0;
				cur_row <= 5'd0;
				cur_idx <= '0;
			end else begin
				cur_idx <= cur_idx + 12'd1;
				if (cur_col == 7'(`COLS - 1)) begin
					cur_col <= 7'd0;
					cur_row <= cur_row + 5'd1;
				end else begin
					cur_col <= cur_col + 7'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ch_valid && !is_newline) begin
			mem[cur_idx] <= ch;
		end
		rd_data <= mem[rd_addr];
	end

endmodule

/* src/key_decoder.sv */
`timescale 1ns/1ps
`include "text_term_macros.svh"

module key_decoder (
	input  logic                      clk,
	input  logic                      rst_n,
	input  text_term_pkg::scan_code_t code,
	input  logic                      code_valid,
	output text_term_pkg::ascii_t     ch,
	output logic                      ch_valid
);

	logic break_pending;
	logic map_hit;
	text_term_pkg::ascii_t map_ch;

	always_comb begin
		map_hit = 1'b1;
		case (code)
			8'h1C: map_ch = "A";
			8'h32: map_ch = "B";
			8'h21: map_ch = "C";
			8'h23: map_ch = "D";
			8'h24: map_ch = "E";
			8'h2B: map_ch = "F";
			8'h34: map_ch = "G";
			8'h33: map_ch = "H";
			8'h43: map_ch = "I";
			8'h3B: map_ch = "J";
			8'h42: map_ch = "K";
			8'h4B: map_ch = "L";
			8'h3A: map_ch = "M";
			8'h31: map_ch = "N";
			8'h44: map_ch = "O";
			8'h4D: map_ch = "P";
			8'h15: map_ch = "Q";
			8'h2D: map_ch = "R";
			8'h1B: map_ch = "S";
			8'h2C: map_ch = "T";
			8'h3C: map_ch = "U";
			8'h2A: map_ch = "V";
			8'h1D: map_ch = "W";
			8'h22: map_ch = "X";
			8'h35: map_ch = "Y";
			8'h1A: map_ch = "Z";
			8'h45: map_ch = "0";
			8'h16: map_ch = "1";
			8'h1E: map_ch = "2";
			8'h26: map_ch = "3";
			8'h25: map_ch = "4";
			8'h2E: map_ch = "5";
			8'h36: map_ch = "6";
			8'h3D: map_ch = "7";
			8'h3E: map_ch = "8";
			8'h46: map_ch = "9";
			8'h29: map_ch = " ";
			`KEY_ENTER: map_ch = `CHAR_NEWLINE;
			default: begin
				map_ch = 8'h00;
				map_hit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			break_pending <= 1'b0;
			ch_valid <= 1'b0;
		end else begin
			ch_valid <= 1'b0;
			if (code_valid) begin
				if (code == `KEY_BREAK) begin
					break_pending <= 1'b1;
				end else if (break_pending) begin
					// released key, swallow it
					break_pending <= 1'b0;
				end else begin
					ch_valid <= map_hit;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (code_valid) begin
			ch <= map_ch;
		end
	end

endmodule

/* src/ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ps2_clk,
	input  logic                      ps2_data,
	output text_term_pkg::scan_code_t code,
	output logic                      code_valid,
	output logic                      frame_error
);

	logic [2:0] clk_sync;
	logic [1:0] data_sync;
	logic ps2_fall;
	logic bit_in;
	text_term_pkg::rx_state_t state;
	logic [2:0] bit_cnt;
	logic parity_acc;
	text_term_pkg::scan_code_t shift_reg;

	// two sync flops, the third one only for edge detection
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clk_sync <= 3'b111;
			data_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	assign ps2_fall = clk_sync[2] & ~clk_sync[1];
	assign bit_in = data_sync[1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= text_term_pkg::IDLE;
			bit_cnt <= 3'd0;
			parity_acc <= 1'b0;
			code_valid <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			frame_error <= 1'b0;
			if (ps2_fall) begin
				case (state)
					text_term_pkg::IDLE: begin
						if (!bit_in) begin
							state <= text_term_pkg::DATA;
							bit_cnt <= 3'd0;
							parity_acc <= 1'b0;
						end else begin
							frame_error <= 1'b1;
						end
					end
					text_term_pkg::DATA: begin
						parity_acc <= parity_acc ^ bit_in;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= text_term_pkg::PARITY;
						end
					end
					text_term_pkg::PARITY: begin
						parity_acc <= parity_acc ^ bit_in;
						state <= text_term_pkg::STOP;
					end
					default: begin
						// odd parity leaves the accumulator at 1
						if (bit_in && parity_acc) begin
							code_valid <= 1'b1;
						end else begin
							frame_error <= 1'b1;
						end
						state <= text_term_pkg::IDLE;
					end
				endcase
			end
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (ps2_fall && state == text_term_pkg::DATA) begin
			shift_reg <= {bit_in, shift_reg[7:1]};
		end
		if (ps2_fall && state == text_term_pkg::STOP) begin
			code <= shift_reg;
		end
	end

endmodule

/* src/text_term_pkg.sv */
package text_term_pkg;

	typedef logic [7:0] scan_code_t;

	// 0 marks an empty cell
	typedef logic [7:0] ascii_t;

	// row * 80 + column
	typedef logic [11:0] cell_addr_t;

	typedef logic [9:0] pix_x_t;
	typedef logic [9:0] pix_y_t;

	typedef logic [3:0] glyph_row_t;
	typedef logic [2:0] glyph_col_t;

	typedef enum logic [1:0] {
		IDLE,
		DATA,
		PARITY,
		STOP
	} rx_state_t;

endpackage

/* src/text_term_macros.svh */
`ifndef TEXT_TERM_MACROS_SVH
`define TEXT_TERM_MACROS_SVH

// 640x480 horizontal timing, in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// vertical timing, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// glyph cell and text grid
`define CELL_W 8
`define CELL_H 16
`define COLS 80
`define ROWS 30
`define CELLS 2400

// set-2 scan codes and the newline character
`define KEY_BREAK 8'hF0
`define KEY_ENTER 8'h5A
`define CHAR_NEWLINE 8'h0A

`endif
